//--- Bender.yml
package:
  name: pong_render

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pong_pkg.sv
      - frame_timer.sv
      - score_keeper.sv
      - box_raster.sv
      - render_sequencer.sv
      - pong_render_top.sv
      - target: test
        files:
          - pong_render_props.sv
          - tb_clock_gen.sv
          - tb_pong_render.sv

//--- box_raster.sv
`timescale 1ns/1ps

module box_raster import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic job_start,
	input box_job_t job,
	output pixel_t pixel,
	output logic plot,
	output logic done
);

	box_job_t job_q;
	box_job_t cur_job;
	x_coord_t col;
	y_coord_t row;
	x_coord_t cur_col;
	y_coord_t cur_row;
	logic active;
	logic emit;
	logic last_px;
	logic last_q;

	// a fresh start overrides whatever box is in flight
	assign cur_job = job_start ? job : job_q;
	assign cur_col = job_start ? '0 : col;
	assign cur_row = job_start ? '0 : row;
	assign emit = job_start | active;
	assign last_px = (cur_col == cur_job.w - 1'b1) && (cur_row == cur_job.h - 1'b1);

	// control
	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			plot <= 1'b0;
			last_q <= 1'b0;
			done <= 1'b0;
		end else begin
			plot <= emit;
			last_q <= emit & last_px;
			done <= last_q & ~job_start;
			if (emit)
				active <= ~last_px;
		end
	end

	// datapath, row-major walk from the top-left corner
	always_ff @(posedge clk) begin
		if (job_start)
			job_q <= job;
		if (emit) begin
			pixel.x <= cur_job.x + cur_col;
			pixel.y <= cur_job.y + cur_row;
			pixel.colour <= cur_job.colour;
			if (cur_col == cur_job.w - 1'b1) begin
				col <= '0;
				row <= cur_row + 1'b1;
			end else begin
				col <= cur_col + 1'b1;
				row <= cur_row;
			end
		end
	end

endmodule

//--- frame_timer.sv
`timescale 1ns/1ps
`include "pong_macros.svh"

module frame_timer (
	input logic clk,
	input logic resetn,
	input logic enable,
	output logic frame_tick
);

	localparam int unsigned CNT_W = $clog2(`FRAME_CYCLES);

	logic [CNT_W-1:0] count;

	// counts down only while enabled, tick on the cycle after zero is seen
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= CNT_W'(`FRAME_CYCLES - 1);
			frame_tick <= 1'b0;
		end else begin
			frame_tick <= 1'b0;
			if (enable) begin
				if (count == '0) begin
					count <= CNT_W'(`FRAME_CYCLES - 1);
					frame_tick <= 1'b1;
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

endmodule

//--- pong_macros.svh
`ifndef PONG_MACROS_SVH
`define PONG_MACROS_SVH

// display geometry
`define SCREEN_W 320
`define SCREEN_H 240

// object sizes in pixels
`define BALL_W 4
`define BALL_H 4
`define PADDLE_W 5
`define PADDLE_H 40

// left paddle column, the right one sits flush with the right edge
`define PADDLE_LEFT_X 2

// clock cycles per frame, small for simulation
`define FRAME_CYCLES 2000

// highest score before the counters wrap
`define MAX_SCORE 7

`endif

//--- pong_pkg.sv
`include "pong_macros.svh"

package pong_pkg;

	// widths sized to hold the full screen extent
	typedef logic [$clog2(`SCREEN_W + 1) - 1:0] x_coord_t;
	typedef logic [$clog2(`SCREEN_H + 1) - 1:0] y_coord_t;

	// 3-bit rgb
	typedef logic [2:0] colour_t;

	typedef logic [$clog2(`MAX_SCORE + 1) - 1:0] score_t;

	// one pixel write to the display
	typedef struct packed {
		x_coord_t x;
		y_coord_t y;
		colour_t colour;
	} pixel_t;

	// rectangle fill request for the rasterizer
	typedef struct packed {
		x_coord_t x;
		y_coord_t y;
		x_coord_t w;
		y_coord_t h;
		colour_t colour;
	} box_job_t;

	// object positions as shown by the game
	typedef struct packed {
		x_coord_t ball_x;
		y_coord_t ball_y;
		y_coord_t left_y;
		y_coord_t right_y;
	} scene_t;

endpackage

//--- pong_render_props.sv
`timescale 1ns/1ps
`include "pong_macros.svh"

module pong_render_props import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input pixel_t pixel,
	input logic plot,
	input score_t lhs_score,
	input score_t rhs_score
);

	// count of failed properties
	int unsigned fails = 0;

	// every write lands on the display
	a_pixel_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (pixel.x < `SCREEN_W && pixel.y < `SCREEN_H))
		else begin
			$error("pixel written outside the screen");
			fails++;
		end

	// scores only step by one, or wrap to zero
	a_lhs_step: assert property (@(posedge clk) disable iff (!resetn)
		(lhs_score != $past(lhs_score)) |->
			(lhs_score == score_t'($past(lhs_score) + 1'b1) || lhs_score == '0))
		else begin
			$error("left score jumped by more than one");
			fails++;
		end

	a_rhs_step: assert property (@(posedge clk) disable iff (!resetn)
		(rhs_score != $past(rhs_score)) |->
			(rhs_score == score_t'($past(rhs_score) + 1'b1) || rhs_score == '0))
		else begin
			$error("right score jumped by more than one");
			fails++;
		end

	a_one_side: assert property (@(posedge clk) disable iff (!resetn)
		!((lhs_score != $past(lhs_score)) && (rhs_score != $past(rhs_score))))
		else begin
			$error("both scores changed in the same cycle");
			fails++;
		end

	a_plot_reset: assert property (@(posedge clk) !resetn |=> !plot)
		else begin
			$error("plot high while in reset");
			fails++;
		end

endmodule

bind pong_render_top pong_render_props u_props (
	.clk(clk),
	.resetn(resetn),
	.pixel(pixel),
	.plot(plot),
	.lhs_score(lhs_score),
	.rhs_score(rhs_score)
);

//--- pong_render_top.sv
`timescale 1ns/1ps

module pong_render_top import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic enable,
	input logic lhs_scored,
	input logic rhs_scored,
	input colour_t colour,
	input scene_t scene,
	output pixel_t pixel,
	output logic plot,
	output score_t lhs_score,
	output score_t rhs_score
);

	logic frame_tick;
	logic score_event;
	logic job_start;
	logic raster_done;
	box_job_t job;

	frame_timer u_frame_timer (
		.clk(clk),
		.resetn(resetn),
		.enable(enable),
		.frame_tick(frame_tick)
	);

	score_keeper u_score_keeper (
		.clk(clk),
		.resetn(resetn),
		.lhs_scored(lhs_scored),
		.rhs_scored(rhs_scored),
		.lhs_score(lhs_score),
		.rhs_score(rhs_score),
		.score_event(score_event)
	);

	render_sequencer u_render_sequencer (
		.clk(clk),
		.resetn(resetn),
		.frame_tick(frame_tick),
		.score_event(score_event),
		.raster_done(raster_done),
		.colour(colour),
		.scene(scene),
		.job(job),
		.job_start(job_start)
	);

	// single rasterizer shared by every object and the blank
	box_raster u_box_raster (
		.clk(clk),
		.resetn(resetn),
		.job_start(job_start),
		.job(job),
		.pixel(pixel),
		.plot(plot),
		.done(raster_done)
	);

endmodule

//--- render_sequencer.sv
`timescale 1ns/1ps
`include "pong_macros.svh"

module render_sequencer import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic frame_tick,
	input logic score_event,
	input logic raster_done,
	input colour_t colour,
	input scene_t scene,
	output box_job_t job,
	output logic job_start
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_LPAD_ERASE,
		S_LPAD_ERASE_WAIT,
		S_LPAD_DRAW,
		S_LPAD_DRAW_WAIT,
		S_RPAD_ERASE,
		S_RPAD_ERASE_WAIT,
		S_RPAD_DRAW,
		S_RPAD_DRAW_WAIT,
		S_BALL_ERASE,
		S_BALL_ERASE_WAIT,
		S_BALL_DRAW,
		S_BALL_DRAW_WAIT,
		S_BLANK,
		S_BLANK_WAIT
	} state_t;

	localparam x_coord_t RPAD_X = x_coord_t'(`SCREEN_W - `PADDLE_W);

	state_t state;
	state_t next_state;
	scene_t cur_scene;
	scene_t old_scene;
	colour_t draw_colour;

	always_comb begin
		next_state = state;
		// scoring wins over everything, even a blank in progress
		if (score_event) begin
			next_state = S_BLANK;
		end else begin
			case (state)
				S_IDLE: if (frame_tick) next_state = S_LPAD_ERASE;
				S_LPAD_ERASE: next_state = S_LPAD_ERASE_WAIT;
				S_LPAD_ERASE_WAIT: if (raster_done) next_state = S_LPAD_DRAW;
				S_LPAD_DRAW: next_state = S_LPAD_DRAW_WAIT;
				S_LPAD_DRAW_WAIT: if (raster_done) next_state = S_RPAD_ERASE;
				S_RPAD_ERASE: next_state = S_RPAD_ERASE_WAIT;
				S_RPAD_ERASE_WAIT: if (raster_done) next_state = S_RPAD_DRAW;
				S_RPAD_DRAW: next_state = S_RPAD_DRAW_WAIT;
				S_RPAD_DRAW_WAIT: if (raster_done) next_state = S_BALL_ERASE;
				S_BALL_ERASE: next_state = S_BALL_ERASE_WAIT;
				S_BALL_ERASE_WAIT: if (raster_done) next_state = S_BALL_DRAW;
				S_BALL_DRAW: next_state = S_BALL_DRAW_WAIT;
				S_BALL_DRAW_WAIT: if (raster_done) next_state = S_IDLE;
				S_BLANK: next_state = S_BLANK_WAIT;
				S_BLANK_WAIT: if (raster_done) next_state = S_IDLE;
				default: next_state = S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	// snapshots taken when a frame starts, old one starts from zero
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur_scene <= '0;
		end else if (state == S_IDLE && frame_tick && !score_event) begin
			cur_scene <= scene;
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && frame_tick && !score_event) begin
			old_scene <= cur_scene;
			draw_colour <= colour;
		end
	end

	assign job_start = (state == S_LPAD_ERASE) || (state == S_LPAD_DRAW) ||
		(state == S_RPAD_ERASE) || (state == S_RPAD_DRAW) ||
		(state == S_BALL_ERASE) || (state == S_BALL_DRAW) ||
		(state == S_BLANK);

	// full-screen black unless an object step is starting
	always_comb begin
		job.x = '0;
		job.y = '0;
		job.w = x_coord_t'(`SCREEN_W);
		job.h = y_coord_t'(`SCREEN_H);
		job.colour = '0;
		case (state)
			S_LPAD_ERASE, S_LPAD_DRAW: begin
				job.x = x_coord_t'(`PADDLE_LEFT_X);
				job.w = x_coord_t'(`PADDLE_W);
				job.h = y_coord_t'(`PADDLE_H);
				job.y = (state == S_LPAD_ERASE) ? old_scene.left_y : cur_scene.left_y;
				job.colour = (state == S_LPAD_ERASE) ? colour_t'(0) : draw_colour;
			end
			S_RPAD_ERASE, S_RPAD_DRAW: begin
				job.x = RPAD_X;
				job.w = x_coord_t'(`PADDLE_W);
				job.h = y_coord_t'(`PADDLE_H);
				job.y = (state == S_RPAD_ERASE) ? old_scene.right_y : cur_scene.right_y;
				job.colour = (state == S_RPAD_ERASE) ? colour_t'(0) : draw_colour;
			end
			S_BALL_ERASE: begin
				job.x = old_scene.ball_x;
				job.y = old_scene.ball_y;
				job.w = x_coord_t'(`BALL_W);
				job.h = y_coord_t'(`BALL_H);
			end
			S_BALL_DRAW: begin
				job.x = cur_scene.ball_x;
				job.y = cur_scene.ball_y;
				job.w = x_coord_t'(`BALL_W);
				job.h = y_coord_t'(`BALL_H);
				job.colour = draw_colour;
			end
			default: ;
		endcase
	end

endmodule

//--- score_keeper.sv
`timescale 1ns/1ps
`include "pong_macros.svh"

module score_keeper import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic lhs_scored,
	input logic rhs_scored,
	output score_t lhs_score,
	output score_t rhs_score,
	output logic score_event
);

	logic lhs_held;
	logic rhs_held;
	logic lhs_rise;
	logic rhs_rise;

	// a level only counts once until it drops again
	assign lhs_rise = lhs_scored & ~lhs_held;
	assign rhs_rise = rhs_scored & ~rhs_held;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lhs_held <= 1'b0;
			rhs_held <= 1'b0;
			lhs_score <= '0;
			rhs_score <= '0;
			score_event <= 1'b0;
		end else begin
			lhs_held <= lhs_scored;
			rhs_held <= rhs_scored;
			score_event <= lhs_rise | rhs_rise;
			// left wins a tie, the right edge is dropped
			if (lhs_rise) begin
				if (lhs_score == score_t'(`MAX_SCORE))
					lhs_score <= '0;
				else
					lhs_score <= lhs_score + 1'b1;
			end else if (rhs_rise) begin
				if (rhs_score == score_t'(`MAX_SCORE))
					rhs_score <= '0;
				else
					rhs_score <= rhs_score + 1'b1;
			end
		end
	end

endmodule

//--- sim.f
+incdir+.
pong_pkg.sv
frame_timer.sv
score_keeper.sv
box_raster.sv
render_sequencer.sv
pong_render_top.sv
pong_render_props.sv
tb_clock_gen.sv
tb_pong_render.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic resetn
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held low for the first 5 rising edges
	initial begin
		resetn = 1'b0;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

//--- tb_pong_render.sv
`timescale 1ns/1ps
`include "pong_macros.svh"

module tb_pong_render import pong_pkg::*; ();

	localparam int PADDLE_PX = `PADDLE_W * `PADDLE_H;
	localparam int BALL_PX = `BALL_W * `BALL_H;
	localparam int FRAME_PX = 4 * PADDLE_PX + 2 * BALL_PX;
	localparam int BLANK_PX = `SCREEN_W * `SCREEN_H;
	localparam int RPAD_X = `SCREEN_W - `PADDLE_W;

	logic clk;
	logic resetn;
	logic enable;
	logic lhs_scored;
	logic rhs_scored;
	colour_t colour;
	scene_t scene;
	pixel_t pixel;
	logic plot;
	score_t lhs_score;
	score_t rhs_score;

	pixel_t px_q[$];
	logic [15:0] lfsr_state = 16'd11;
	scene_t last_scene;
	colour_t last_colour;
	int exp_lhs;
	int exp_rhs;
	int checks;
	int errors;
	int timeouts;

	tb_clock_gen u_clock_gen (.clk(clk), .resetn(resetn));

	pong_render_top DUT (
		.clk(clk), .resetn(resetn), .enable(enable),
		.lhs_scored(lhs_scored), .rhs_scored(rhs_scored),
		.colour(colour), .scene(scene),
		.pixel(pixel), .plot(plot),
		.lhs_score(lhs_score), .rhs_score(rhs_score)
	);

	// pixel monitor, sampled away from the active edge
	always @(negedge clk) begin
		if (resetn === 1'b1 && plot === 1'b1)
			px_q.push_back(pixel);
	end

	// galois lfsr, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// positions that keep every object on screen
	function automatic scene_t random_scene();
		scene_t s;
		s.ball_x = x_coord_t'(take_bits(9) % (`SCREEN_W - `BALL_W + 1));
		s.ball_y = y_coord_t'(take_bits(8) % (`SCREEN_H - `BALL_H + 1));
		s.left_y = y_coord_t'(take_bits(8) % (`SCREEN_H - `PADDLE_H + 1));
		s.right_y = y_coord_t'(take_bits(8) % (`SCREEN_H - `PADDLE_H + 1));
		return s;
	endfunction

	task automatic report(input string msg);
		$display("ERROR @%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic wait_pixels(input int n, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (px_q.size() < n && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (px_q.size() < n) begin
			$display("timeout after %0d cycles waiting for %s", limit, what);
			timeouts++;
		end
	endtask

	// expected box is walked row by row from its top-left corner
	task automatic check_box(input int base, input int x, input int y, input int w,
			input int h, input colour_t col, input string what);
		pixel_t exp;
		int idx;
		int bad;
		int first;
		bad = 0;
		first = 0;
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				idx = base + r * w + c;
				exp.x = x_coord_t'(x + c);
				exp.y = y_coord_t'(y + r);
				exp.colour = col;
				if (idx >= px_q.size() || px_q[idx] !== exp) begin
					if (bad == 0)
						first = idx;
					bad++;
				end
			end
		end
		checks++;
		if (bad != 0)
			report($sformatf("%s has %0d wrong pixels, first at index %0d", what, bad, first));
	endtask

	task automatic check_frame(input int base, input scene_t old_s, input scene_t new_s,
			input colour_t col);
		check_box(base, `PADDLE_LEFT_X, old_s.left_y, `PADDLE_W, `PADDLE_H, 3'd0,
			"left paddle erase");
		check_box(base + PADDLE_PX, `PADDLE_LEFT_X, new_s.left_y, `PADDLE_W, `PADDLE_H,
			col, "left paddle draw");
		check_box(base + 2 * PADDLE_PX, RPAD_X, old_s.right_y, `PADDLE_W, `PADDLE_H,
			3'd0, "right paddle erase");
		check_box(base + 3 * PADDLE_PX, RPAD_X, new_s.right_y, `PADDLE_W, `PADDLE_H,
			col, "right paddle draw");
		check_box(base + 4 * PADDLE_PX, old_s.ball_x, old_s.ball_y, `BALL_W, `BALL_H,
			3'd0, "ball erase");
		check_box(base + 4 * PADDLE_PX + BALL_PX, new_s.ball_x, new_s.ball_y, `BALL_W,
			`BALL_H, col, "ball draw");
	endtask

	task automatic check_count(input int n, input string what);
		repeat (20) @(posedge clk);
		checks++;
		if (px_q.size() != n)
			report($sformatf("%s wrote %0d pixels, expected %0d", what, px_q.size(), n));
	endtask

	task automatic test_reset();
		int cycles;
		cycles = 0;
		while (resetn !== 1'b1 && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (resetn !== 1'b1) begin
			$display("timeout, reset was never released");
			timeouts++;
		end
		@(negedge clk);
		checks++;
		if (plot !== 1'b0 || lhs_score !== '0 || rhs_score !== '0)
			report("outputs not cleared after reset");
		repeat (`FRAME_CYCLES - 2) @(posedge clk);
		checks++;
		if (px_q.size() != 0)
			report("pixels written before the first frame tick");
	endtask

	task automatic test_frame(input scene_t s, input colour_t col, input string what);
		scene <= s;
		colour <= col;
		px_q.delete();
		wait_pixels(FRAME_PX, 2 * `FRAME_CYCLES, what);
		check_count(FRAME_PX, what);
		check_frame(0, last_scene, s, col);
		last_scene = s;
		last_colour = col;
	endtask

	task automatic test_enable_low();
		enable <= 1'b0;
		px_q.delete();
		repeat (3 * `FRAME_CYCLES) @(posedge clk);
		checks++;
		if (px_q.size() != 0)
			report("frame started with enable low");
		enable <= 1'b1;
		wait_pixels(1, `FRAME_CYCLES + 10, "frame after enable");
		wait_pixels(FRAME_PX, `FRAME_CYCLES, "frame after enable");
		check_count(FRAME_PX, "frame after enable");
		check_frame(0, last_scene, last_scene, last_colour);
	endtask

	task automatic score_point(input logic l, input logic r, input string what);
		@(posedge clk);
		px_q.delete();
		lhs_scored <= l;
		rhs_scored <= r;
		if (l)
			exp_lhs = (exp_lhs == `MAX_SCORE) ? 0 : exp_lhs + 1;
		else if (r)
			exp_rhs = (exp_rhs == `MAX_SCORE) ? 0 : exp_rhs + 1;
		wait_pixels(BLANK_PX, BLANK_PX + 100, what);
		// level stays high through the count check
		check_count(BLANK_PX, what);
		check_box(0, 0, 0, `SCREEN_W, `SCREEN_H, 3'd0, what);
		checks++;
		if (lhs_score !== score_t'(exp_lhs) || rhs_score !== score_t'(exp_rhs))
			report($sformatf("%s gave scores %0d/%0d, expected %0d/%0d", what,
				lhs_score, rhs_score, exp_lhs, exp_rhs));
		lhs_scored <= 1'b0;
		rhs_scored <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic test_score_mid_frame();
		scene_t s;
		pixel_t exp;
		int k;
		s = random_scene();
		scene <= s;
		enable <= 1'b1;
		px_q.delete();
		wait_pixels(50, 2 * `FRAME_CYCLES + 10, "frame before score");
		lhs_scored <= 1'b1;
		exp_lhs = (exp_lhs == `MAX_SCORE) ? 0 : exp_lhs + 1;
		wait_pixels(PADDLE_PX + BLANK_PX, BLANK_PX + 3 * `FRAME_CYCLES, "blank mid frame");
		lhs_scored <= 1'b0;
		// length of the erase box prefix before the blank took over
		k = 0;
		while (k < PADDLE_PX && k < px_q.size()) begin
			exp.x = x_coord_t'(`PADDLE_LEFT_X + k % `PADDLE_W);
			exp.y = y_coord_t'(last_scene.left_y + k / `PADDLE_W);
			exp.colour = '0;
			if (px_q[k] !== exp)
				break;
			k++;
		end
		checks++;
		if (k == 0 || k >= PADDLE_PX)
			report($sformatf("interrupted box wrote %0d pixels", k));
		wait_pixels(k + BLANK_PX + FRAME_PX, 3 * `FRAME_CYCLES, "frame after blank");
		check_count(k + BLANK_PX + FRAME_PX, "interrupted frame");
		check_box(k, 0, 0, `SCREEN_W, `SCREEN_H, 3'd0, "blank mid frame");
		check_frame(k + BLANK_PX, s, s, last_colour);
		checks++;
		if (lhs_score !== score_t'(exp_lhs))
			report("score raised mid frame not counted");
	endtask

	initial begin
		checks = 0;
		errors = 0;
		timeouts = 0;
		exp_lhs = 0;
		exp_rhs = 0;
		last_scene = '0;
		enable <= 1'b1;
		lhs_scored <= 1'b0;
		rhs_scored <= 1'b0;
		colour <= 3'd5;
		scene <= '0;
		test_reset();
		test_frame(random_scene(), 3'd5, "first frame");
		test_frame(random_scene(), 3'd3, "second frame");
		test_enable_low();
		enable <= 1'b0;
		score_point(1'b1, 1'b0, "left point");
		score_point(1'b1, 1'b1, "tied point");
		score_point(1'b0, 1'b1, "right point");
		test_score_mid_frame();
		$display("%0d checks, %0d errors, %0d timeouts, %0d assertion failures", checks,
			errors, timeouts, DUT.u_props.fails);
		if (errors == 0 && timeouts == 0 && DUT.u_props.fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
